//--- design/cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 7;
    localparam int WORD_SEL_W     = 3;
    localparam int NUM_SETS       = 128;
    localparam int WORDS_PER_LINE = 8;
    localparam int NUM_WAYS       = 4;

    // fetch address as seen by the cache
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word_sel;
        logic [1:0]            byte_off;
    } fetch_addr_t;

    typedef logic [1:0] way_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    // entry 0 is most recently used, last entry is the victim
    typedef way_t [NUM_WAYS-1:0] lru_order_t;

    typedef logic [WORDS_PER_LINE-1:0][31:0] line_t;

endpackage

//--- design/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
    import cache_geom_pkg::*, mem_bus_pkg::*;
#(
    parameter logic [3:0] AXI_ID = 4'd3
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_req,
    input  fetch_addr_t           inst_addr,
    output logic                  inst_addr_ok,
    output logic                  inst_data_ok,
    output logic [31:0]           inst_rdata,
    output logic [INDEX_W-1:0]    arr_index,
    output logic [TAG_W-1:0]      lookup_tag,
    input  logic [NUM_WAYS-1:0]   way_hit,
    input  line_t [NUM_WAYS-1:0]  way_line,
    input  way_t                  victim,
    output logic                  hit_update,
    output way_t                  hit_way,
    output logic [NUM_WAYS-1:0]   tag_wr_en,
    output logic [NUM_WAYS-1:0]   data_wr_en,
    output logic [WORD_SEL_W-1:0] wr_word_sel,
    output logic [31:0]           wr_word,
    output ar_req_t               ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  r_beat_t               r,
    input  logic                  rvalid,
    output logic                  rready
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_AR,
        REFILL,
        REREAD
    } state_t;

    state_t                state;
    fetch_addr_t           req_addr;
    way_t                  victim_way;
    logic [WORD_SEL_W-1:0] beat_cnt;
    logic                  any_hit;
    logic                  beat;
    logic                  refill_done;
    logic [NUM_WAYS-1:0]   victim_onehot;
    line_t                 hit_line;

    assign any_hit     = |way_hit;
    assign beat        = (state == REFILL) && rvalid;
    assign refill_done = beat && r.last && (r.id == AXI_ID);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:    if (inst_req) state <= LOOKUP;
                LOOKUP:  state <= any_hit ? IDLE : MISS_AR;
                MISS_AR: if (arready) state <= REFILL;
                REFILL:  if (refill_done) state <= REREAD;
                REREAD:  state <= LOOKUP;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == IDLE) && inst_req)
        begin
            req_addr <= inst_addr;
        end
        // victim chosen once per miss, before the refill touches the set
        if ((state == LOOKUP) && !any_hit)
        begin
            victim_way <= victim;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || refill_done)
        begin
            beat_cnt <= '0;
        end
        else if (beat)
        begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // incoming index while idle so the arrays read on the accept edge
    assign arr_index  = (state == IDLE) ? inst_addr.index : req_addr.index;
    assign lookup_tag = req_addr.tag;

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (way_hit[w])
            begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_line     = way_line[hit_way];
    assign inst_rdata   = hit_line[req_addr.word_sel];
    assign inst_addr_ok = (state == IDLE);
    assign inst_data_ok = (state == LOOKUP) && any_hit;
    assign hit_update   = (state == LOOKUP) && any_hit;

    assign victim_onehot = {{(NUM_WAYS-1){1'b0}}, 1'b1} << victim_way;
    assign data_wr_en    = beat ? victim_onehot : '0;
    assign tag_wr_en     = refill_done ? victim_onehot : '0;
    assign wr_word_sel   = beat_cnt;
    assign wr_word       = r.data;

    // line-aligned burst for the whole line
    assign ar.id    = AXI_ID;
    assign ar.addr  = {req_addr.tag, req_addr.index, {(WORD_SEL_W + 2){1'b0}}};
    assign ar.len   = BURST_LEN_LINE;
    assign ar.size  = BEAT_SIZE_WORD;
    assign ar.burst = BURST_INCR;
    assign arvalid  = (state == MISS_AR);
    assign rready   = (state == REFILL);

endmodule

//--- design/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array
    import cache_geom_pkg::*;
#(
    parameter int SETS = NUM_SETS
)
(
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [INDEX_W-1:0]    wr_index,
    input  logic [WORD_SEL_W-1:0] wr_word_sel,
    input  logic [31:0]           wr_word,
    input  logic [INDEX_W-1:0]    rd_index,
    output line_t                 rd_line
);

    line_t line_mem [SETS];

    // refill writes one word per beat
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            line_mem[wr_index][wr_word_sel] <= wr_word;
        end
    end

    // whole line out, word picked later by the controller
    always_ff @(posedge clk)
    begin
        rd_line <= line_mem[rd_index];
    end

endmodule

//--- design/icache_lru.sv
`timescale 1ns/1ps

module icache_lru
    import cache_geom_pkg::*;
#(
    parameter int SETS = NUM_SETS
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] index,
    input  logic               hit_update,
    input  way_t               hit_way,
    output way_t               victim
);

    lru_order_t order [SETS];
    lru_order_t cur;
    lru_order_t promoted;
    way_t       hit_pos;

    // find where the hit way sits in the list
    always_comb
    begin
        cur     = order[index];
        hit_pos = '0;
        for (int i = 0; i < NUM_WAYS; i++)
        begin
            if (cur[i] == hit_way)
            begin
                hit_pos = way_t'(i);
            end
        end
    end

    // hit way to the front, the ones ahead of it slide back one slot
    always_comb
    begin
        promoted[0] = hit_way;
        for (int i = 1; i < NUM_WAYS; i++)
        begin
            if (i <= int'(hit_pos))
            begin
                promoted[i] = cur[i-1];
            end
            else
            begin
                promoted[i] = cur[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                for (int w = 0; w < NUM_WAYS; w++)
                begin
                    order[s][w] <= way_t'(w);
                end
            end
        end
        else if (hit_update)
        begin
            order[index] <= promoted;
        end
    end

    assign victim = cur[NUM_WAYS-1];

endmodule

//--- design/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array
    import cache_geom_pkg::*;
#(
    parameter int SETS = NUM_SETS
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] rd_index,
    input  logic [TAG_W-1:0]   lookup_tag,
    input  logic               wr_en,
    input  logic [INDEX_W-1:0] wr_index,
    input  logic [TAG_W-1:0]   wr_tag,
    output logic               hit
);

    logic [SETS-1:0]  valid_bits;
    logic [TAG_W-1:0] tag_mem [SETS];
    tag_entry_t       rd_entry;

    // valid bits live in flops so reset can clear every set
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_bits <= '0;
        end
        else if (wr_en)
        begin
            valid_bits[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            tag_mem[wr_index] <= wr_tag;
        end
    end

    // synchronous read, old contents on a same-cycle write
    always_ff @(posedge clk)
    begin
        rd_entry.valid <= valid_bits[rd_index];
        rd_entry.tag   <= tag_mem[rd_index];
    end

    assign hit = rd_entry.valid && (rd_entry.tag == lookup_tag);

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ps

module icache_top
    import cache_geom_pkg::*, mem_bus_pkg::*;
#(
    parameter logic [3:0] AXI_ID = 4'd3,
    parameter int         SETS   = NUM_SETS
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_req,
    input  fetch_addr_t inst_addr,
    output logic        inst_addr_ok,
    output logic        inst_data_ok,
    output logic [31:0] inst_rdata,
    output ar_req_t     ar,
    output logic        arvalid,
    input  logic        arready,
    input  r_beat_t     r,
    input  logic        rvalid,
    output logic        rready
);

    logic [INDEX_W-1:0]    arr_index;
    logic [TAG_W-1:0]      lookup_tag;
    logic [NUM_WAYS-1:0]   way_hit;
    line_t [NUM_WAYS-1:0]  way_line;
    logic [NUM_WAYS-1:0]   tag_wr_en;
    logic [NUM_WAYS-1:0]   data_wr_en;
    logic [WORD_SEL_W-1:0] wr_word_sel;
    logic [31:0]           wr_word;
    logic                  hit_update;
    way_t                  hit_way;
    way_t                  victim;

    // refill writes go to the stored index and tag
    for (genvar g = 0; g < NUM_WAYS; g++)
    begin : g_way
        icache_tag_array #(.SETS(SETS)) u_tag (
            .clk        (clk),
            .rst        (rst),
            .rd_index   (arr_index),
            .lookup_tag (lookup_tag),
            .wr_en      (tag_wr_en[g]),
            .wr_index   (arr_index),
            .wr_tag     (lookup_tag),
            .hit        (way_hit[g])
        );

        icache_data_array #(.SETS(SETS)) u_data (
            .clk         (clk),
            .wr_en       (data_wr_en[g]),
            .wr_index    (arr_index),
            .wr_word_sel (wr_word_sel),
            .wr_word     (wr_word),
            .rd_index    (arr_index),
            .rd_line     (way_line[g])
        );
    end

    icache_lru #(.SETS(SETS)) u_lru (
        .clk        (clk),
        .rst        (rst),
        .index      (arr_index),
        .hit_update (hit_update),
        .hit_way    (hit_way),
        .victim     (victim)
    );

    icache_ctrl #(.AXI_ID(AXI_ID)) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .arr_index    (arr_index),
        .lookup_tag   (lookup_tag),
        .way_hit      (way_hit),
        .way_line     (way_line),
        .victim       (victim),
        .hit_update   (hit_update),
        .hit_way      (hit_way),
        .tag_wr_en    (tag_wr_en),
        .data_wr_en   (data_wr_en),
        .wr_word_sel  (wr_word_sel),
        .wr_word      (wr_word),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready)
    );

endmodule

//--- design/mem_bus_pkg.sv
package mem_bus_pkg;

    // AXI read address channel payload
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } ar_req_t;

    // AXI read data channel payload
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } r_beat_t;

    localparam logic [1:0] BURST_INCR     = 2'b01;
    localparam logic [2:0] BEAT_SIZE_WORD = 3'd2;

    // eight beats per line, AXI len is beats minus one
    localparam logic [7:0] BURST_LEN_LINE = 8'd7;

endpackage

//--- run.sh
#!/usr/bin/env bash
# compile and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_icache \
    -f sources.f \
    -o sim_icache

# the simulator's own exit status is not used, the log decides
./obj_dir/sim_icache | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED"
    exit 1
fi

//--- sources.f
+incdir+tb
design/cache_geom_pkg.sv
design/mem_bus_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_lru.sv
design/icache_ctrl.sv
design/icache_top.sv
tb/tb_icache.sv

//--- tb/icache_ref_model.svh
`ifndef ICACHE_REF_MODEL_SVH
`define ICACHE_REF_MODEL_SVH

import cache_geom_pkg::*;
import mem_bus_pkg::*;

// per-set state, order entry 0 is the most recent way
bit               model_valid [NUM_SETS][NUM_WAYS];
logic [TAG_W-1:0] model_tag   [NUM_SETS][NUM_WAYS];
int               model_order [NUM_SETS][NUM_WAYS];

// memory content, every address bit takes part
function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
endfunction

function automatic ar_req_t expected_ar(input fetch_addr_t a);
    ar_req_t e;
    e.id    = 4'd3;
    // 32-byte line boundary
    e.addr  = 32'(a) & 32'hffff_ffe0;
    e.len   = 8'd7;
    e.size  = 3'd2;
    e.burst = 2'b01;
    return e;
endfunction

function automatic void model_reset();
    for (int s = 0; s < NUM_SETS; s++)
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            model_valid[s][w] = 1'b0;
            model_tag[s][w]   = '0;
            model_order[s][w] = w;
        end
    end
endfunction

// move a way to the front, ways ahead of it slide back one slot
function automatic void model_promote(input int set, input int way);
    int pos;
    pos = 0;
    for (int i = 0; i < NUM_WAYS; i++)
    begin
        if (model_order[set][i] == way)
        begin
            pos = i;
        end
    end
    for (int i = pos; i > 0; i--)
    begin
        model_order[set][i] = model_order[set][i-1];
    end
    model_order[set][0] = way;
endfunction

// 1 on a predicted hit; a miss fills the last way, which the reread hit promotes
function automatic bit model_access(input fetch_addr_t a);
    int set;
    int way;
    set = a.index;
    way = -1;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
        if (model_valid[set][w] && (model_tag[set][w] == a.tag))
        begin
            way = w;
        end
    end
    if (way >= 0)
    begin
        model_promote(set, way);
        return 1'b1;
    end
    way = model_order[set][NUM_WAYS-1];
    model_valid[set][way] = 1'b1;
    model_tag[set][way]   = a.tag;
    model_promote(set, way);
    return 1'b0;
endfunction

`endif

//--- tb/tb_icache.sv
`timescale 1ns/1ps

module tb_icache
    import cache_geom_pkg::*, mem_bus_pkg::*;
;

    localparam int ACCEPT_TIMEOUT = 10;
    localparam int FETCH_TIMEOUT  = 100;
    localparam int RANDOM_FETCHES = 300;

    `include "icache_ref_model.svh"

    logic        clk;
    logic        rst;
    logic        inst_req;
    fetch_addr_t inst_addr;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic [31:0] inst_rdata;
    ar_req_t     ar;
    logic        arvalid;
    logic        arready = 1'b0;
    r_beat_t     r       = '0;
    logic        rvalid  = 1'b0;
    logic        rready;

    integer      seed;
    int          pick;
    int          ar_count   = 0;
    bit          ar_pending = 1'b0;
    int          ar_delay   = 0;
    bit          r_active   = 1'b0;
    int          beat_idx   = 0;
    int          gap        = 0;
    logic [31:0] rd_base    = '0;
    fetch_addr_t cur_addr   = '0;

    logic [TAG_W-1:0]   tag_pool [6] = '{20'h0_0123, 20'h4_5670, 20'h8_9ab0,
                                         20'hc_def1, 20'h1_2345, 20'hf_0f0f};
    logic [INDEX_W-1:0] index_pool [3] = '{7'h03, 7'h2a, 7'h7f};

    icache_top #(.AXI_ID(4'd3), .SETS(NUM_SETS)) UUT (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_and_stop(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    function automatic fetch_addr_t make_addr(input logic [TAG_W-1:0] tag,
                                              input logic [INDEX_W-1:0] index,
                                              input logic [WORD_SEL_W-1:0] word_sel);
        fetch_addr_t a;
        a.tag      = tag;
        a.index    = index;
        a.word_sel = word_sel;
        a.byte_off = 2'b00;
        return a;
    endfunction

    function automatic r_beat_t make_beat(input logic [31:0] base, input int idx);
        r_beat_t b;
        b.id   = 4'd3;
        b.data = mem_word(base + 32'(idx * 4));
        b.resp = 2'b00;
        b.last = (idx == WORDS_PER_LINE - 1);
        return b;
    endfunction

    // one fetch from request to data_ok, checked against the model
    task automatic run_fetch(input fetch_addr_t a, output bit pred_hit);
        int          waited;
        int          lat;
        int          ar_before;
        logic [31:0] exp_data;
        pred_hit = model_access(a);
        exp_data = mem_word(a);
        cur_addr = a;
        @(posedge clk);
        inst_req  <= 1'b1;
        inst_addr <= a;
        waited = 0;
        @(negedge clk);
        // a second data_ok for the previous fetch would show up here
        assert (!inst_data_ok)
        else report_and_stop($sformatf("[FAIL] inst_data_ok = %h, expected %h",
                                       inst_data_ok, 1'b0));
        while (!inst_addr_ok)
        begin
            waited++;
            if (waited > ACCEPT_TIMEOUT)
            begin
                report_and_stop("timeout waiting for inst_addr_ok");
            end
            @(negedge clk);
            assert (!inst_data_ok)
            else report_and_stop($sformatf("[FAIL] inst_data_ok = %h, expected %h",
                                           inst_data_ok, 1'b0));
        end
        ar_before = ar_count;
        @(posedge clk);
        inst_req <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (!inst_data_ok)
        begin
            lat++;
            if (lat > FETCH_TIMEOUT)
            begin
                report_and_stop("timeout waiting for inst_data_ok");
            end
            @(negedge clk);
        end
        assert (inst_rdata == exp_data)
        else report_and_stop($sformatf("[FAIL] inst_rdata = %h, expected %h",
                                       inst_rdata, exp_data));
        if (pred_hit)
        begin
            assert (lat == 1)
            else report_and_stop($sformatf("[FAIL] inst_data_ok latency = %h, expected %h",
                                           lat, 1));
            assert (ar_count == ar_before)
            else report_and_stop("an AR was issued for a fetch the model predicts as a hit");
        end
        else
        begin
            assert (ar_count == ar_before + 1)
            else report_and_stop($sformatf("[FAIL] AR count for miss = %h, expected %h",
                                           ar_count - ar_before, 1));
        end
    endtask

    // AXI read slave with random arready delay and beat gaps
    always @(posedge clk)
    begin
        if (rst)
        begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            ar_pending <= 1'b0;
            r_active   <= 1'b0;
        end
        else
        begin
            assert (rready == r_active)
            else report_and_stop($sformatf("[FAIL] rready = %h, expected %h", rready, r_active));
            if (arvalid && arready)
            begin
                assert (ar == expected_ar(cur_addr))
                else report_and_stop($sformatf("[FAIL] ar = %h, expected %h",
                                               ar, expected_ar(cur_addr)));
                ar_count   <= ar_count + 1;
                arready    <= 1'b0;
                ar_pending <= 1'b0;
                r_active   <= 1'b1;
                rd_base    <= ar.addr;
                beat_idx   <= 0;
                pick = $unsigned($random(seed)) % 4;
                if (pick == 0)
                begin
                    r      <= make_beat(ar.addr, 0);
                    rvalid <= 1'b1;
                end
                else
                begin
                    gap <= pick - 1;
                end
            end
            else if (arvalid && !arready)
            begin
                if (!ar_pending)
                begin
                    pick = $unsigned($random(seed)) % 4;
                    ar_pending <= 1'b1;
                    ar_delay   <= pick;
                    if (pick == 0)
                    begin
                        arready <= 1'b1;
                    end
                end
                else if (ar_delay <= 1)
                begin
                    arready <= 1'b1;
                end
                else
                begin
                    ar_delay <= ar_delay - 1;
                end
            end
            if (r_active)
            begin
                if (rvalid)
                begin
                    // rready is high through the refill, so this beat was taken
                    if (beat_idx == WORDS_PER_LINE - 1)
                    begin
                        rvalid   <= 1'b0;
                        r_active <= 1'b0;
                    end
                    else
                    begin
                        pick = $unsigned($random(seed)) % 4;
                        beat_idx <= beat_idx + 1;
                        if (pick == 0)
                        begin
                            r <= make_beat(rd_base, beat_idx + 1);
                        end
                        else
                        begin
                            rvalid <= 1'b0;
                            gap    <= pick - 1;
                        end
                    end
                end
                else if (gap == 0)
                begin
                    r      <= make_beat(rd_base, beat_idx);
                    rvalid <= 1'b1;
                end
                else
                begin
                    gap <= gap - 1;
                end
            end
        end
    end

    initial
    begin
        fetch_addr_t      a;
        bit               hit;
        int               hits;
        int               misses;
        logic [TAG_W-1:0] dir_tag [5];
        seed      = 32'h5ccb_6f14;
        rst       = 1'b1;
        inst_req  = 1'b0;
        inst_addr = '0;
        hits      = 0;
        misses    = 0;
        model_reset();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!inst_data_ok && !arvalid && !rready)
        else report_and_stop($sformatf("[FAIL] data_ok/arvalid/rready = %h, expected %h",
                                       {inst_data_ok, arvalid, rready}, 3'b000));

        // five tags into one set, the first one gets evicted
        for (int k = 0; k < 5; k++)
        begin
            dir_tag[k] = 20'h0_a000 | 20'(k);
            run_fetch(make_addr(dir_tag[k], 7'h55, 3'(k)), hit);
            assert (!hit)
            else report_and_stop("model predicts a hit while filling an empty set");
        end
        for (int k = 1; k < 5; k++)
        begin
            run_fetch(make_addr(dir_tag[k], 7'h55, 3'(k + 3)), hit);
            assert (hit)
            else report_and_stop("model predicts a miss for a line still in the set");
        end
        run_fetch(make_addr(dir_tag[0], 7'h55, 3'd6), hit);
        assert (!hit)
        else report_and_stop("model predicts a hit for the evicted line");

        for (int n = 0; n < RANDOM_FETCHES; n++)
        begin
            a = make_addr(tag_pool[$unsigned($random(seed)) % 6],
                          index_pool[$unsigned($random(seed)) % 3],
                          3'($random(seed)));
            run_fetch(a, hit);
            if (hit)
            begin
                hits++;
            end
            else
            begin
                misses++;
            end
        end

        @(negedge clk);
        assert (!inst_data_ok)
        else report_and_stop($sformatf("[FAIL] inst_data_ok = %h, expected %h",
                                       inst_data_ok, 1'b0));
        assert ((hits > 0) && (misses > 0))
        else report_and_stop("random fetches did not produce both hits and misses");
        $display("All tests passed!");
        $finish;
    end

endmodule
